/* Bender.yml */
package:
  name: bitpack

sources:
  - bitpack_pkg.sv
  - word_fifo.sv
  - bit_fifo.sv
  - bit_packer.sv
  - bitpack_top.sv
  - target: test
    files:
      - bitpack_asserts.sv
      - tb_bitpack.sv

/* bit_fifo.sv */
`default_nettype none

module bit_fifo #(
   parameter int WDATA_W = 12,
   parameter int RDATA_W = 16
) (
   input  wire logic                                      clk_i,
   input  wire logic                                      arst_n_i,

   // push a variable-length field MSB aligned in wdata_i
   input  wire logic                                      write_i,
   input  wire logic [bitpack_pkg::cnt_w(WDATA_W)-1:0]    wlen_i,
   input  wire logic [WDATA_W-1:0]                        wdata_i,
   output logic [bitpack_pkg::cnt_w(
      2 * bitpack_pkg::max_w(WDATA_W, RDATA_W))-1:0]      wlevel_o,

   // pop a full word from the top
   input  wire logic                                      read_i,
   output logic [RDATA_W-1:0]                             rdata_o,
   output logic [bitpack_pkg::cnt_w(
      2 * bitpack_pkg::max_w(WDATA_W, RDATA_W))-1:0]      rlevel_o
);

   import bitpack_pkg::*;

   localparam int REG_W   = 2 * max_w(WDATA_W, RDATA_W);
   localparam int LEVEL_W = cnt_w(REG_W);

   // filled bits sit at the top of data_q with the oldest bit in the MSB
   logic [REG_W-1:0]   data_q;
   logic [REG_W-1:0]   data_nxt;
   logic [LEVEL_W-1:0] level_q;
   logic [LEVEL_W-1:0] level_nxt;

   // state after an optional pop and before the push lands
   logic [REG_W-1:0]   popped_data;
   logic [LEVEL_W-1:0] popped_level;

   // incoming field spread over the register width
   logic [REG_W-1:0]   wide_field;
   logic [REG_W-1:0]   field_mask;
   logic [REG_W-1:0]   keep_mask;
   logic [REG_W-1:0]   placed_field;

   assign wide_field = {wdata_i, {(REG_W - WDATA_W){1'b0}}};

   // only the top wlen_i bits of the field are meaningful
   assign field_mask = ~({REG_W{1'b1}} >> wlen_i);

   always_comb begin
      popped_data  = data_q;
      popped_level = level_q;
      if (read_i) begin
         popped_data  = data_q << RDATA_W;
         popped_level = level_q - LEVEL_W'(RDATA_W);
      end
   end

   // bits past the fill level may hold stale data and are cleared here
   assign keep_mask    = ~({REG_W{1'b1}} >> popped_level);
   assign placed_field = (wide_field & field_mask) >> popped_level;

   always_comb begin
      data_nxt  = popped_data & keep_mask;
      level_nxt = popped_level;
      if (write_i) begin
         data_nxt  = data_nxt | placed_field;
         level_nxt = popped_level + LEVEL_W'(wlen_i);
      end
   end

   always_ff @(posedge clk_i) begin
      data_q <= data_nxt;
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         level_q <= '0;
      end else begin
         level_q <= level_nxt;
      end
   end

   assign rdata_o  = data_q[REG_W-1 -: RDATA_W];
   assign rlevel_o = level_q;
   assign wlevel_o = LEVEL_W'(REG_W) - level_q;

endmodule

`default_nettype wire

/* bit_packer.sv */
`default_nettype none

module bit_packer #(
   parameter int UNPACKED_DATA_W = 12,
   parameter int PACKED_DATA_W   = 16
) (
   input  wire logic                                          clk_i,
   input  wire logic                                          arst_n_i,

   // quasi-static packing setup
   input  wire logic [bitpack_pkg::cnt_w(UNPACKED_DATA_W)-1:0] len_i,
   input  wire logic                                          wrap_i,

   // unpacked words from the input fifo
   output logic                                               read_o,
   input  wire logic                                          rready_i,
   input  wire logic [UNPACKED_DATA_W-1:0]                    rdata_i,

   // packed words to the output fifo
   output logic                                               write_o,
   input  wire logic                                          wready_i,
   output logic [PACKED_DATA_W-1:0]                           wdata_o
);

   import bitpack_pkg::*;

   localparam int REG_W   = 2 * max_w(UNPACKED_DATA_W, PACKED_DATA_W);
   localparam int LEVEL_W = cnt_w(REG_W);
   localparam int LEN_W   = cnt_w(UNPACKED_DATA_W);
   localparam int ACC_W   = $clog2(PACKED_DATA_W);

   pack_action_e action;

   // held word, captured from the head of the input fifo
   logic                       held;
   logic                       held_nxt;
   logic [UNPACKED_DATA_W-1:0] held_data;
   logic [UNPACKED_DATA_W-1:0] field_data;

   // bit fifo control
   logic                       push;
   logic [LEN_W-1:0]           push_len;
   logic [UNPACKED_DATA_W-1:0] push_data;
   logic [LEVEL_W-1:0]         push_level;
   logic                       pop;
   logic [LEVEL_W-1:0]         pop_level;

   // bit position inside the packed word being built
   logic [ACC_W-1:0]           wrap_acc;
   logic [ACC_W-1:0]           wrap_acc_nxt;
   logic [ACC_W:0]             acc_sum;
   logic [LEN_W-1:0]           pad_len;
   logic                       fits;

   // low len_i bits moved to the top of the word
   assign field_data = held_data << (UNPACKED_DATA_W - int'(len_i));

   assign acc_sum = {1'b0, wrap_acc} + (ACC_W + 1)'(len_i);
   assign fits    = !wrap_i || (acc_sum <= (ACC_W + 1)'(PACKED_DATA_W));

   // padding is only used when the field straddles, so it stays below UNPACKED_DATA_W
   assign pad_len = LEN_W'((ACC_W + 1)'(PACKED_DATA_W) - {1'b0, wrap_acc});

   // one action per cycle, highest priority first
   always_comb begin
      action = ACT_IDLE;
      if (held && fits && push_level >= LEVEL_W'(len_i)) begin
         action = ACT_PUSH;
      end else if (held && !fits && push_level >= LEVEL_W'(pad_len)) begin
         action = ACT_WRAP;
      end else if (pop_level >= LEVEL_W'(PACKED_DATA_W) && wready_i) begin
         action = ACT_POP;
      end else if (!held && rready_i) begin
         action = ACT_LOAD;
      end
   end

   always_comb begin
      push         = 1'b0;
      push_len     = len_i;
      push_data    = field_data;
      pop          = 1'b0;
      read_o       = 1'b0;
      held_nxt     = held;
      wrap_acc_nxt = wrap_acc;
      case (action)
         ACT_PUSH: begin
            push         = 1'b1;
            wrap_acc_nxt = acc_sum[ACC_W-1:0];
            // refill straight away when another word is waiting
            if (rready_i) begin
               read_o = 1'b1;
            end else begin
               held_nxt = 1'b0;
            end
         end
         ACT_WRAP: begin
            push         = 1'b1;
            push_len     = pad_len;
            push_data    = '0;
            wrap_acc_nxt = '0;
         end
         ACT_POP: begin
            pop = 1'b1;
         end
         ACT_LOAD: begin
            read_o   = 1'b1;
            held_nxt = 1'b1;
         end
         default: begin
         end
      endcase
   end

   assign write_o = pop;

   always_ff @(posedge clk_i) begin
      if (read_o) begin
         held_data <= rdata_i;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         held     <= 1'b0;
         wrap_acc <= '0;
      end else begin
         held     <= held_nxt;
         wrap_acc <= wrap_acc_nxt;
      end
   end

   bit_fifo #(
      .WDATA_W (UNPACKED_DATA_W),
      .RDATA_W (PACKED_DATA_W)
   ) u_bit_fifo (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .write_i  (push),
      .wlen_i   (push_len),
      .wdata_i  (push_data),
      .wlevel_o (push_level),
      .read_i   (pop),
      .rdata_o  (wdata_o),
      .rlevel_o (pop_level)
   );

endmodule

`default_nettype wire

/* bitpack_asserts.sv */
`default_nettype none

module bitpack_asserts #(
   parameter int UNPACKED_DATA_W = 12,
   parameter int PACKED_DATA_W   = 16
) (
   input wire logic                     clk_i,
   input wire logic                     arst_n_i,
   input wire logic                     read_i,
   input wire logic                     write_i,
   input wire logic                     wready_i,
   input wire logic                     push_i,
   input wire logic                     pop_i,
   input wire bitpack_pkg::pack_action_e action_i,
   input wire logic [bitpack_pkg::cnt_w(
      2 * bitpack_pkg::max_w(UNPACKED_DATA_W, PACKED_DATA_W))-1:0] level_i
);
   timeunit 1ns;
   timeprecision 1ps;

   import bitpack_pkg::*;

   localparam int REG_W = 2 * max_w(UNPACKED_DATA_W, PACKED_DATA_W);

   int unsigned fail_count = 0;

   a_quiet_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> (!read_i && !write_i))
      else begin
         $error("packer strobes active during reset");
         fail_count++;
      end

   a_write_with_room: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      write_i |-> wready_i)
      else begin
         $error("packed word written while the output fifo is full");
         fail_count++;
      end

   // pop and push never share a cycle
   a_single_action: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $onehot0({push_i, pop_i}))
      else begin
         $error("more than one packer action in a cycle");
         fail_count++;
      end

   // a pop takes exactly one packed word out of the bit fifo
   a_pop_step: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (action_i == ACT_POP) |=> (level_i == $past(level_i) - PACKED_DATA_W))
      else begin
         $error("bit fifo fill did not drop by one packed word after a pop");
         fail_count++;
      end

   a_level_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      level_i <= REG_W)
      else begin
         $error("bit fifo fill exceeds its register width");
         fail_count++;
      end

endmodule

bind bit_packer bitpack_asserts #(
   .UNPACKED_DATA_W (UNPACKED_DATA_W),
   .PACKED_DATA_W   (PACKED_DATA_W)
) u_asserts (
   .clk_i    (clk_i),
   .arst_n_i (arst_n_i),
   .read_i   (read_o),
   .write_i  (write_o),
   .wready_i (wready_i),
   .push_i   (push),
   .pop_i    (pop),
   .action_i (action),
   .level_i  (pop_level)
);

`default_nettype wire

/* bitpack_pkg.sv */
`default_nettype none

package bitpack_pkg;

   // default geometry of the subsystem
   localparam int DEF_UNPACKED_DATA_W = 12;
   localparam int DEF_PACKED_DATA_W   = 16;
   localparam int DEF_FIFO_DEPTH      = 8;

   // the larger of two widths
   function automatic int max_w(int a, int b);
      return (a > b) ? a : b;
   endfunction

   // bits needed for a length or level that may reach n itself
   function automatic int cnt_w(int n);
      return $clog2(n) + 1;
   endfunction

   // the one thing the packer does in a given cycle
   typedef enum logic [2:0] {
      ACT_IDLE,
      // field of the held word goes into the bit fifo
      ACT_PUSH,
      // zero padding up to the next word boundary
      ACT_WRAP,
      // full packed word leaves for the output fifo
      ACT_POP,
      // head of the input fifo is captured
      ACT_LOAD
   } pack_action_e;

endpackage

`default_nettype wire

/* bitpack_top.sv */
`default_nettype none

module bitpack_top #(
   parameter int UNPACKED_DATA_W = bitpack_pkg::DEF_UNPACKED_DATA_W,
   parameter int PACKED_DATA_W   = bitpack_pkg::DEF_PACKED_DATA_W,
   parameter int FIFO_DEPTH      = bitpack_pkg::DEF_FIFO_DEPTH
) (
   input  wire logic                                          clk_i,
   input  wire logic                                          arst_n_i,

   input  wire logic [bitpack_pkg::cnt_w(UNPACKED_DATA_W)-1:0] len_i,
   input  wire logic                                          wrap_i,

   // unpacked word source
   input  wire logic                                          in_write_i,
   input  wire logic [UNPACKED_DATA_W-1:0]                    in_data_i,
   output logic                                               in_full_o,

   // packed word sink
   input  wire logic                                          out_read_i,
   output logic [PACKED_DATA_W-1:0]                           out_data_o,
   output logic                                               out_empty_o
);

   logic                       in_empty;
   logic [UNPACKED_DATA_W-1:0] in_head;
   logic                       pk_read;
   logic                       pk_write;
   logic [PACKED_DATA_W-1:0]   pk_wdata;
   logic                       out_full;

   word_fifo #(
      .DATA_W (UNPACKED_DATA_W),
      .DEPTH  (FIFO_DEPTH)
   ) u_in_fifo (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .write_i  (in_write_i),
      .data_i   (in_data_i),
      .full_o   (in_full_o),
      .read_i   (pk_read),
      .data_o   (in_head),
      .empty_o  (in_empty)
   );

   bit_packer #(
      .UNPACKED_DATA_W (UNPACKED_DATA_W),
      .PACKED_DATA_W   (PACKED_DATA_W)
   ) u_packer (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .len_i    (len_i),
      .wrap_i   (wrap_i),
      .read_o   (pk_read),
      .rready_i (!in_empty),
      .rdata_i  (in_head),
      .write_o  (pk_write),
      .wready_i (!out_full),
      .wdata_o  (pk_wdata)
   );

   word_fifo #(
      .DATA_W (PACKED_DATA_W),
      .DEPTH  (FIFO_DEPTH)
   ) u_out_fifo (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .write_i  (pk_write),
      .data_i   (pk_wdata),
      .full_o   (out_full),
      .read_i   (out_read_i),
      .data_o   (out_data_o),
      .empty_o  (out_empty_o)
   );

endmodule

`default_nettype wire

/* flist.f */
bitpack_pkg.sv
word_fifo.sv
bit_fifo.sv
bit_packer.sv
bitpack_top.sv
bitpack_asserts.sv
tb_bitpack.sv

/* tb_bitpack.sv */
`default_nettype none

module tb_bitpack;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int UW    = bitpack_pkg::DEF_UNPACKED_DATA_W;
   localparam int PW    = bitpack_pkg::DEF_PACKED_DATA_W;
   localparam int LEN_W = bitpack_pkg::cnt_w(UW);

   logic             clk_i = 1'b0;
   logic             arst_n_i;
   logic [LEN_W-1:0] len_i;
   logic             wrap_i;
   logic             in_write_i;
   logic [UW-1:0]    in_data_i;
   logic             in_full_o;
   logic             out_read_i;
   logic [PW-1:0]    out_data_o;
   logic             out_empty_o;

   // bits of the word being built and the finished words of the model
   bit            bit_q[$];
   logic [PW-1:0] exp_q[$];

   // field lengths that do not divide the packed width
   int odd_lens[8] = '{3, 5, 6, 7, 9, 10, 11, 12};
   int word_checks = 0;
   int word_errs   = 0;
   int flag_errs   = 0;
   int other_errs  = 0;
   bit aborted     = 1'b0;
   bit full_seen   = 1'b0;

   bitpack_top #(
      .UNPACKED_DATA_W (UW),
      .PACKED_DATA_W   (PW),
      .FIFO_DEPTH      (bitpack_pkg::DEF_FIFO_DEPTH)
   ) UUT (.*);

   always #20 clk_i = ~clk_i;

   task automatic check_word(input string name, input logic [PW-1:0] got,
                             input logic [PW-1:0] exp);
      word_checks++;
      if (got !== exp) begin
         $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
         word_errs++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
         flag_errs++;
      end
   endtask

   function automatic void model_bit(input bit b);
      logic [PW-1:0] w;
      bit_q.push_back(b);
      if (bit_q.size() == PW) begin
         for (int i = 0; i < PW; i++) begin
            w[PW-1-i] = bit_q[i];
         end
         exp_q.push_back(w);
         bit_q.delete();
      end
   endfunction

   // low len bits MSB first with zero padding up to the boundary when wrapping
   function automatic void model_add(input logic [UW-1:0] data, input int len, input bit wrap);
      int pad;
      if (wrap && (bit_q.size() + len > PW)) begin
         pad = PW - bit_q.size();
         repeat (pad) model_bit(1'b0);
      end
      for (int i = len - 1; i >= 0; i--) begin
         model_bit(data[i]);
      end
   endfunction

   task automatic take_word();
      if (exp_q.size() == 0) begin
         $display("output word 0x%h appeared with no word left in the model", out_data_o);
         other_errs++;
      end else begin
         check_word("out_data_o", out_data_o, exp_q.pop_front());
      end
   endtask

   // one idle-to-idle run with the sink held off for the first stall cycles
   task automatic run_stream(input int len, input bit wrap, input int n_words,
                             input int write_pct, input int read_pct, input int stall);
      int            sent;
      int            cycles;
      int            limit;
      logic [UW-1:0] data;
      if (aborted) return;
      len_i  = LEN_W'(len);
      wrap_i = wrap;
      sent   = 0;
      cycles = 0;
      limit  = stall + n_words * 20 + 200;
      while ((sent < n_words || exp_q.size() > 0) && cycles < limit) begin
         @(posedge clk_i);
         #2;
         in_write_i = 1'b0;
         out_read_i = 1'b0;
         if (in_full_o) full_seen = 1'b1;
         if (sent < n_words && !in_full_o && $urandom_range(99) < write_pct) begin
            data       = UW'($urandom);
            in_data_i  = data;
            in_write_i = 1'b1;
            model_add(data, len, wrap);
            sent++;
         end
         if (!out_empty_o && cycles >= stall && $urandom_range(99) < read_pct) begin
            take_word();
            out_read_i = 1'b1;
         end
         cycles++;
      end
      if (sent < n_words || exp_q.size() > 0) begin
         $display("timeout: run with len %0d did not deliver all expected words", len);
         other_errs++;
         aborted = 1'b1;
         return;
      end
      // leftover bits stay in the bit fifo, so no full word may follow
      repeat (10) begin
         @(posedge clk_i);
         #2;
         in_write_i = 1'b0;
         out_read_i = 1'b0;
      end
      check_flag("out_empty_o", out_empty_o, 1'b1);
      check_flag("in_full_o", in_full_o, 1'b0);
   endtask

   initial begin
      int total;
      void'($urandom(98));
      arst_n_i   = 1'b0;
      len_i      = LEN_W'(UW);
      wrap_i     = 1'b0;
      in_write_i = 1'b0;
      in_data_i  = '0;
      out_read_i = 1'b0;
      repeat (2) @(posedge clk_i);
      #2;
      arst_n_i = 1'b1;
      check_flag("out_empty_o", out_empty_o, 1'b1);
      check_flag("in_full_o", in_full_o, 1'b0);

      run_stream($urandom_range(1, UW), 1'b0, 40, 70, 80, 0);
      run_stream(odd_lens[$urandom_range(7)], 1'b1, 40, 70, 80, 0);
      run_stream(UW, 1'b0, 40, 90, 90, 0);

      // long sink stall, then a slow sink
      full_seen = 1'b0;
      run_stream(UW, 1'b0, 60, 100, 30, 80);
      if (!aborted && !full_seen) begin
         $display("in_full_o never rose while the output side was stalled");
         other_errs++;
      end

      for (int r = 0; r < 4; r++) begin
         run_stream($urandom_range(1, UW), $urandom_range(1), 24, 60, 60, 0);
      end

      total = word_errs + flag_errs + other_errs + UUT.u_packer.u_asserts.fail_count;
      $display("words checked %0d, word errors %0d, flag errors %0d, other errors %0d, %s %0d",
               word_checks, word_errs, flag_errs, other_errs, "assertion errors",
               UUT.u_packer.u_asserts.fail_count);
      if (total == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* word_fifo.sv */
`default_nettype none

module word_fifo #(
   parameter int DATA_W = 16,
   parameter int DEPTH  = 8
) (
   input  wire logic              clk_i,
   input  wire logic              arst_n_i,

   // write side
   input  wire logic              write_i,
   input  wire logic [DATA_W-1:0] data_i,
   output logic                   full_o,

   // read side, head word always on data_o
   input  wire logic              read_i,
   output logic [DATA_W-1:0]      data_o,
   output logic                   empty_o
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [DATA_W-1:0] mem [DEPTH];
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [CNT_W-1:0]  count;
   logic              do_write;
   logic              do_read;

   // strobes against a full or empty buffer are dropped
   assign do_write = write_i && !full_o;
   assign do_read  = read_i && !empty_o;

   assign full_o  = (count == CNT_W'(DEPTH));
   assign empty_o = (count == '0);
   assign data_o  = mem[rd_ptr];

   always_ff @(posedge clk_i) begin
      if (do_write) begin
         mem[wr_ptr] <= data_i;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_write) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_read) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // count only moves when exactly one side is active
         if (do_write && !do_read) begin
            count <= count + 1'b1;
         end else if (do_read && !do_write) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire
